//--- ppu_bg.f
src/ppu_pkg.sv
src/ppu_axil_regs.sv
src/ppu_dot_timing.sv
src/bg_pixel.sv
src/ppu_byte_mem.sv
src/ppu_bg_top.sv
tests/ppu_bg_asserts.sv
tests/tb_ppu_bg.sv

//--- Bender.yml
package:
  name: ppu_bg

sources:
  - files:
      - src/ppu_pkg.sv
      - src/ppu_axil_regs.sv
      - src/ppu_dot_timing.sv
      - src/bg_pixel.sv
      - src/ppu_byte_mem.sv
      - src/ppu_bg_top.sv
  - target: test
    files:
      - tests/ppu_bg_asserts.sv
      - tests/tb_ppu_bg.sv

//--- tests/tb_ppu_bg.sv
`timescale 1ns/1ps

module tb_ppu_bg;
    import ppu_pkg::*;

    localparam int DOTS_PER_LINE   = 260;
    localparam int LINES_PER_FRAME = 242;
    localparam int CLK_PERIOD      = 100;
    localparam int FRAME_BEATS     = VISIBLE_ROWS * VISIBLE_COLS;
    localparam int N_FRAMES        = 6;
    localparam int N_AXI_OPS       = 10500;  // memory load dominates
    localparam int WATCHDOG_NS     = CLK_PERIOD *
        (N_FRAMES * (DOTS_PER_LINE * LINES_PER_FRAME + 16) + N_AXI_OPS * 16);

    logic        clk = 1'b0;
    logic        rst_n;
    logic [4:0]  awaddr, araddr;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0]  wstrb;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [3:0]  bg_color_idx;
    logic [8:0]  pix_row, pix_col;
    logic        pix_valid;

    logic [7:0]  vram_m [2048];
    logic [7:0]  chr_m [8192];
    logic [4:0]  m_ctrl;
    logic [15:0] m_scroll;
    logic [13:0] m_addr;
    logic        bp_on;    // random bready and rready
    int          beats;

    ppu_bg_top #(
        .DOTS_PER_LINE   (DOTS_PER_LINE),
        .LINES_PER_FRAME (LINES_PER_FRAME)
    ) ppu_bg_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic is_mapped(input logic [4:0] a);
        return a inside {REG_CTRL, REG_SCROLL, REG_ADDR, REG_DATA};
    endfunction

    function automatic logic ready_bit();
        return bp_on ? ($urandom_range(0, 2) == 0) : 1'b1;
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] a);
        case (a)
            REG_CTRL:   return {27'd0, m_ctrl};
            REG_SCROLL: return {16'd0, m_scroll};
            REG_ADDR:   return {18'd0, m_addr};
            default:    return 32'd0;
        endcase
    endfunction

    task automatic model_write(input logic [4:0] a, input logic [31:0] d, input logic [3:0] s);
        case (a)
            REG_CTRL:   if (s[0]) m_ctrl = d[4:0];
            REG_SCROLL: begin
                if (s[0]) m_scroll[7:0] = d[7:0];
                if (s[1]) m_scroll[15:8] = d[15:8];
            end
            REG_ADDR: begin
                if (s[0]) m_addr[7:0] = d[7:0];
                if (s[1]) m_addr[13:8] = d[13:8];
            end
            REG_DATA: if (s[0]) begin
                if (!m_ctrl[0] && m_addr < CHR_TOP)
                    chr_m[m_addr[12:0]] = d[7:0];
                else if (!m_ctrl[0])
                    vram_m[m_addr[10:0]] = d[7:0];  // nametables fold to 2 KiB
                m_addr = m_addr + 14'd1;
            end
            default: ;
        endcase
    endtask

    // expected color index of one screen dot
    function automatic logic [3:0] model_pixel(input int row, input int col);
        int          y, x, base, tile, sh;
        logic [1:0]  nt, pal, color;
        logic [7:0]  attr, lo, hi;
        logic [12:0] pa;
        y  = row + m_scroll[15:8];
        x  = col + m_scroll[7:0];
        nt = m_ctrl[3:2];
        if (m_scroll[15:8] >= VISIBLE_ROWS)
            y = y - 256;  // scroll_y past the table scrolls upward
        if (y < 0 || y >= VISIBLE_ROWS) begin
            y     = (y < 0) ? y + VISIBLE_ROWS : y - VISIBLE_ROWS;
            nt[1] = ~nt[1];
        end
        if (x >= 256) begin
            x     = x - 256;
            nt[0] = ~nt[0];
        end
        base  = (m_ctrl[4] ? nt[0] : nt[1]) ? 1024 : 0;
        tile  = vram_m[base + (y / 8) * 32 + x / 8];
        attr  = vram_m[base + ATTR_TBL_OFF + (y / 32) * 8 + x / 32];
        sh    = ((y / 16) % 2) * 4 + ((x / 16) % 2) * 2;
        pal   = attr[sh +: 2];
        pa    = 13'(m_ctrl[1] * 4096 + tile * 16 + y % 8);
        lo    = chr_m[pa];
        hi    = chr_m[pa + 13'd8];
        color = {hi[7 - x % 8], lo[7 - x % 8]};
        return (color == 2'b00) ? 4'h0 : {pal, color};
    endfunction

    task automatic axi_write(input logic [4:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [1:0] held;
        logic       seen;
        model_write(a, d, s);
        awaddr  <= a;
        awvalid <= 1'b1;
        wdata   <= d;
        wstrb   <= s;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!awready);
        check_eq("wready", wready, 1'b1);  // raised together with awready
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        seen = 1'b0;
        bready <= ready_bit();
        @(posedge clk);
        while (!(bvalid && bready)) begin
            if (bvalid && seen)
                check_eq("bresp", bresp, held);
            held = bresp;
            seen = bvalid;
            bready <= ready_bit();
            @(posedge clk);
        end
        if (seen)
            check_eq("bresp", bresp, held);
        check_eq("bresp", bresp, is_mapped(a) ? 2'b00 : 2'b10);
        bready <= 1'b0;
    endtask

    task automatic read_check(input logic [4:0] a, input logic [31:0] exp);
        logic [33:0] held;
        logic        seen;
        araddr  <= a;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        seen = 1'b0;
        rready <= ready_bit();
        @(posedge clk);
        while (!(rvalid && rready)) begin
            if (rvalid && seen)
                check_eq("rresp_rdata", {rresp, rdata}, held);
            held = {rresp, rdata};
            seen = rvalid;
            rready <= ready_bit();
            @(posedge clk);
        end
        if (seen)
            check_eq("rresp_rdata", {rresp, rdata}, held);
        if (is_mapped(a))
            check_eq("rdata", rdata, exp);
        check_eq("rresp", rresp, is_mapped(a) ? 2'b00 : 2'b10);
        rready <= 1'b0;
    endtask

    // one full visible frame, optionally with DATA writes while it draws
    task automatic render_frame(input logic [4:0] ctrl, input logic [15:0] scroll, input int locked);
        axi_write(REG_SCROLL, {16'd0, scroll}, 4'h3);
        beats = 0;
        axi_write(REG_CTRL, {27'd0, ctrl[4:1], 1'b1}, 4'h1);
        repeat (locked) axi_write(REG_DATA, $urandom, 4'hF);
        wait (beats == FRAME_BEATS);
        @(posedge clk);
        axi_write(REG_CTRL, {27'd0, ctrl[4:1], 1'b0}, 4'h1);
    endtask

    always @(negedge clk) begin
        if (rst_n === 1'b1 && pix_valid === 1'b1) begin
            check_eq("pix_row", pix_row, beats / VISIBLE_COLS);  // raster order from 0,0
            check_eq("pix_col", pix_col, beats % VISIBLE_COLS);
            check_eq("bg_color_idx", bg_color_idx, model_pixel(pix_row, pix_col));
            beats = beats + 1;
        end
    end

    always @(negedge clk) begin
        if (ppu_bg_top_inst.ppu_bg_asserts_inst.fail_cnt != 0) begin
            $display("Error: a concurrent assertion on the DUT failed");
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired before all frames and bus accesses completed");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        logic [4:0]  a;
        logic [31:0] d;
        logic [7:0]  sy;
        void'($urandom(12));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        m_ctrl   = '0;
        m_scroll = '0;
        m_addr   = '0;
        beats    = 0;
        bp_on    = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        repeat (40) begin
            a = 5'(4 * $urandom_range(0, 2));
            d = $urandom;
            if (a == REG_CTRL)
                d[0] = 1'b0;  // memory still empty, keep rendering off
            axi_write(a, d, 4'($urandom));
            read_check(a, reg_value(a));
        end
        read_check(REG_DATA, 32'd0);
        repeat (4) begin
            a = 5'h10 | 5'($urandom_range(0, 15));  // above the register map
            axi_write(a, $urandom, 4'hF);
            read_check(a, 32'd0);
        end

        // fill all of CHR then run on into VRAM
        bp_on = 1'b0;
        axi_write(REG_ADDR, 32'h0, 4'h3);
        repeat (8192 + 2048) axi_write(REG_DATA, $urandom, 4'h1);
        read_check(REG_ADDR, 32'h2800);
        bp_on = 1'b1;

        render_frame(5'b00000, 16'h0000, 0);
        render_frame(5'b00010, 16'h0000, 0);
        render_frame(5'($urandom), 16'($urandom), 24);
        read_check(REG_ADDR, 32'h2800 + 24);  // dropped writes still count
        for (int i = 0; i < 3; i++) begin
            sy = (i == 0) ? 8'(240 + $urandom_range(0, 15)) : 8'($urandom);
            render_frame({i[0], 2'($urandom), 1'($urandom), 1'b0}, {sy, 8'($urandom)}, 0);
        end

        @(negedge clk);
        if (ppu_bg_top_inst.ppu_bg_asserts_inst.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Error: a concurrent assertion on the DUT failed");
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    end

endmodule

//--- tests/ppu_bg_asserts.sv
`timescale 1ns/1ps

module ppu_bg_asserts (
    input logic        clk,
    input logic        rst_n,
    input logic        awvalid,
    input logic        awready,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        pix_valid,
    input logic [3:0]  bg_color_idx
);

    int unsigned fail_cnt = 0;  // failed assertions so far

    // master side keeps the request up
    assert property (@(posedge clk) disable iff (!rst_n) awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("write response dropped or changed before bready");
            fail_cnt++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("read response dropped or changed before rready");
            fail_cnt++;
        end

    assert property (@(posedge clk) !rst_n |=> !pix_valid)
        else begin
            $error("pix_valid high during reset");
            fail_cnt++;
        end

    // backdrop entries never leave the renderer
    assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid |-> !(bg_color_idx inside {4'h4, 4'h8, 4'hC}))
        else begin
            $error("bg_color_idx is a backdrop mirror entry");
            fail_cnt++;
        end

endmodule

bind ppu_bg_top ppu_bg_asserts ppu_bg_asserts_inst (.*);

//--- src/ppu_bg_top.sv
`timescale 1ns/1ps

module ppu_bg_top #(
    parameter int DOTS_PER_LINE   = 341,
    parameter int LINES_PER_FRAME = 262
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [4:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic [3:0]  bg_color_idx,
    output logic [8:0]  pix_row,
    output logic [8:0]  pix_col,
    output logic        pix_valid
);
    import ppu_pkg::*;

    logic         render_en;
    pattern_tbl_t patt_tbl;
    name_tbl_t    name_tbl;
    mirror_t      mirroring;
    logic [7:0]   scroll_x, scroll_y;
    logic         vram_we, chr_we;
    logic [12:0]  mem_addr;
    logic [7:0]   mem_wdata;
    logic [8:0]   sl_row, sl_col;
    logic         visible;
    logic [10:0]  vram_addr1, vram_addr2;
    logic [12:0]  chr_rom_addr1, chr_rom_addr2;
    logic [7:0]   vram_data1, vram_data2;
    logic [7:0]   chr_rom_data1, chr_rom_data2;

    ppu_axil_regs regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .render_en (render_en),
        .patt_tbl  (patt_tbl),
        .name_tbl  (name_tbl),
        .mirroring (mirroring),
        .scroll_x  (scroll_x),
        .scroll_y  (scroll_y),
        .vram_we   (vram_we),
        .chr_we    (chr_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    ppu_dot_timing #(
        .DOTS_PER_LINE   (DOTS_PER_LINE),
        .LINES_PER_FRAME (LINES_PER_FRAME)
    ) timing_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .render_en (render_en),
        .sl_row    (sl_row),
        .sl_col    (sl_col),
        .visible   (visible)
    );

    bg_pixel bg_pixel_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .sl_row        (sl_row),
        .sl_col        (sl_col),
        .visible       (visible),
        .patt_tbl      (patt_tbl),
        .name_tbl      (name_tbl),
        .mirroring     (mirroring),
        .ppuscroll_x   (scroll_x),
        .ppuscroll_y   (scroll_y),
        .vram_addr1    (vram_addr1),
        .vram_addr2    (vram_addr2),
        .chr_rom_addr1 (chr_rom_addr1),
        .chr_rom_addr2 (chr_rom_addr2),
        .vram_data1    (vram_data1),
        .vram_data2    (vram_data2),
        .chr_rom_data1 (chr_rom_data1),
        .chr_rom_data2 (chr_rom_data2),
        .bg_color_idx  (bg_color_idx),
        .pix_row       (pix_row),
        .pix_col       (pix_col),
        .pix_valid     (pix_valid)
    );

    // 2 KiB of nametable ram
    ppu_byte_mem #(
        .ADDR_W (11)
    ) vram_inst (
        .clk    (clk),
        .we     (vram_we),
        .waddr  (mem_addr[10:0]),
        .wdata  (mem_wdata),
        .raddr1 (vram_addr1),
        .raddr2 (vram_addr2),
        .rdata1 (vram_data1),
        .rdata2 (vram_data2)
    );

    // 8 KiB pattern memory
    ppu_byte_mem #(
        .ADDR_W (13)
    ) chr_inst (
        .clk    (clk),
        .we     (chr_we),
        .waddr  (mem_addr),
        .wdata  (mem_wdata),
        .raddr1 (chr_rom_addr1),
        .raddr2 (chr_rom_addr2),
        .rdata1 (chr_rom_data1),
        .rdata2 (chr_rom_data2)
    );

endmodule

//--- src/ppu_byte_mem.sv
`timescale 1ns/1ps

module ppu_byte_mem #(
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [7:0]        wdata,
    input  logic [ADDR_W-1:0] raddr1,
    input  logic [ADDR_W-1:0] raddr2,
    output logic [7:0]        rdata1,
    output logic [7:0]        rdata2
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0] mem [DEPTH];

    // loaded from the CPU side only
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // both read ports are combinational
    assign rdata1 = mem[raddr1];
    assign rdata2 = mem[raddr2];

endmodule

//--- src/bg_pixel.sv
`timescale 1ns/1ps

module bg_pixel (
    input  logic                  clk,
    input  logic                  rst_n,
    // dot being drawn
    input  logic [8:0]            sl_row,
    input  logic [8:0]            sl_col,
    input  logic                  visible,
    // render setup
    input  ppu_pkg::pattern_tbl_t patt_tbl,
    input  ppu_pkg::name_tbl_t    name_tbl,
    input  ppu_pkg::mirror_t      mirroring,
    input  logic [7:0]            ppuscroll_x,
    input  logic [7:0]            ppuscroll_y,
    // vram, port 1 for tiles, port 2 for attributes
    output logic [10:0]           vram_addr1,
    output logic [10:0]           vram_addr2,
    // chr, low and high bitplane
    output logic [12:0]           chr_rom_addr1,
    output logic [12:0]           chr_rom_addr2,
    input  logic [7:0]            vram_data1,
    input  logic [7:0]            vram_data2,
    input  logic [7:0]            chr_rom_data1,
    input  logic [7:0]            chr_rom_data2,
    // registered pixel
    output logic [3:0]            bg_color_idx,
    output logic [8:0]            pix_row,
    output logic [8:0]            pix_col,
    output logic                  pix_valid
);
    import ppu_pkg::*;

    logic [9:0] row_sum;
    logic [8:0] col_sum;
    logic [7:0] row, col;
    logic       row_ovf, col_ovf;

    // scroll_y of 240 and up counts as a negative offset
    assign row_sum = {1'b0, sl_row} + {2'b00, ppuscroll_y};

    always_comb begin
        if (ppuscroll_y < VISIBLE_ROWS) begin
            row_ovf = (row_sum >= VISIBLE_ROWS);
            row     = row_ovf ? 8'(row_sum - VISIBLE_ROWS) : row_sum[7:0];
        end else begin
            row_ovf = (row_sum < 10'd256);  // dot still above the table edge
            row     = row_ovf ? 8'(row_sum - 10'd16) : row_sum[7:0];
        end
    end

    assign col_sum = sl_col + {1'b0, ppuscroll_x};
    assign col_ovf = col_sum[8];    // past column 255
    assign col     = col_sum[7:0];

    // nametable select, flips to the neighbour on overflow
    logic [10:0] nametbl_off;
    logic        tbl_sel;

    always_comb begin
        if (mirroring == VER_MIRROR)
            tbl_sel = name_tbl[0] ^ col_ovf;  // left and right differ
        else
            tbl_sel = name_tbl[1] ^ row_ovf;  // top and bottom differ
        nametbl_off = {tbl_sel, 10'd0};
    end

    logic [7:0] tile_idx;
    logic [7:0] attr_blk;

    assign vram_addr1 = nametbl_off + {1'b0, row[7:3], col[7:3]}; // 32 tiles per row
    assign tile_idx   = vram_data1;

    // one attribute byte per 32x32 block
    assign vram_addr2 = nametbl_off + ATTR_TBL_OFF + {5'd0, row[7:5], col[7:5]};
    assign attr_blk   = vram_data2;

    logic [1:0] pal_idx;

    always_comb begin
        case ({row[4], col[4]})
            2'b00:   pal_idx = attr_blk[1:0];  // top left
            2'b01:   pal_idx = attr_blk[3:2];
            2'b10:   pal_idx = attr_blk[5:4];
            default: pal_idx = attr_blk[7:6];  // bottom right
        endcase
    end

    // 16 bytes per tile, planes 8 apart
    assign chr_rom_addr1 = {patt_tbl == RIGHT_TBL, tile_idx, 1'b0, row[2:0]};
    assign chr_rom_addr2 = chr_rom_addr1 + 13'd8;

    logic [2:0] bit_idx;
    logic [1:0] color_idx;
    logic [3:0] pix_idx;

    assign bit_idx   = 3'd7 - col[2:0];   // msb is the leftmost dot
    assign color_idx = {chr_rom_data2[bit_idx], chr_rom_data1[bit_idx]};

    // color 0 of every palette shows the backdrop
    assign pix_idx = (color_idx == 2'b00) ? 4'h0 : {pal_idx, color_idx};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pix_valid <= 1'b0;
        else
            pix_valid <= visible;
    end

    always_ff @(posedge clk) begin
        if (visible) begin
            bg_color_idx <= pix_idx;
            pix_row      <= sl_row;
            pix_col      <= sl_col;
        end
    end

endmodule

//--- src/ppu_dot_timing.sv
`timescale 1ns/1ps

module ppu_dot_timing #(
    parameter int DOTS_PER_LINE   = 341,
    parameter int LINES_PER_FRAME = 262
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       render_en,
    output logic [8:0] sl_row,
    output logic [8:0] sl_col,
    output logic       visible
);
    import ppu_pkg::*;

    logic last_col, last_row;

    assign last_col = (sl_col == 9'(DOTS_PER_LINE - 1));
    assign last_row = (sl_row == 9'(LINES_PER_FRAME - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sl_row <= '0;
            sl_col <= '0;
        end else if (!render_en) begin
            sl_row <= '0;  // parked at the frame start
            sl_col <= '0;
        end else if (last_col) begin
            sl_col <= '0;
            sl_row <= last_row ? 9'd0 : sl_row + 9'd1;
        end else begin
            sl_col <= sl_col + 9'd1;
        end
    end

    // no dots leave while rendering is off
    assign visible = render_en && (sl_row < VISIBLE_ROWS) && (sl_col < VISIBLE_COLS);

endmodule

//--- src/ppu_axil_regs.sv
`timescale 1ns/1ps

module ppu_axil_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    // write address and data
    input  logic [4:0]                awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    // write response
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    // read address and data
    input  logic [4:0]                araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // register fields
    output logic                      render_en,
    output ppu_pkg::pattern_tbl_t     patt_tbl,
    output ppu_pkg::name_tbl_t        name_tbl,
    output ppu_pkg::mirror_t          mirroring,
    output logic [7:0]                scroll_x,
    output logic [7:0]                scroll_y,
    // memory write strobes
    output logic                      vram_we,
    output logic                      chr_we,
    output logic [12:0]               mem_addr,
    output logic [7:0]                mem_wdata
);
    import ppu_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [4:0]  ctrl_q;
    logic [13:0] addr_q;   // PPU address, auto-increments on DATA
    logic        idle;
    logic        wr_hs, rd_hs;
    logic        wr_mapped, rd_mapped;
    logic        data_wr;
    logic [31:0] rd_word;

    assign render_en = ctrl_q[0];
    assign patt_tbl  = pattern_tbl_t'(ctrl_q[1]);
    assign name_tbl  = name_tbl_t'(ctrl_q[3:2]);
    assign mirroring = mirror_t'(ctrl_q[4]);

    // one transaction at a time, nothing new while a response waits
    assign idle  = !awready && !arready && !bvalid && !rvalid;
    assign wr_hs = awready && awvalid && wvalid;
    assign rd_hs = arready && arvalid;

    assign wr_mapped = awaddr inside {REG_CTRL, REG_SCROLL, REG_ADDR, REG_DATA};
    assign rd_mapped = araddr inside {REG_CTRL, REG_SCROLL, REG_ADDR, REG_DATA};
    assign data_wr   = wr_hs && (awaddr == REG_DATA) && wstrb[0];

    always_comb begin
        case (araddr)
            REG_CTRL:   rd_word = {27'd0, ctrl_q};
            REG_SCROLL: rd_word = {16'd0, scroll_y, scroll_x};
            REG_ADDR:   rd_word = {18'd0, addr_q};
            default:    rd_word = 32'd0; // DATA reads as zero
        endcase
    end

    // handshake and response flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (idle && awvalid && wvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end else if (idle && arvalid) begin
                arready <= 1'b1;
            end
            if (wr_hs) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (wr_hs)
            bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // register file
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q   <= '0;
            scroll_x <= '0;
            scroll_y <= '0;
            addr_q   <= '0;
        end else if (wr_hs) begin
            case (awaddr)
                REG_CTRL: begin
                    if (wstrb[0]) ctrl_q <= wdata[4:0];
                end
                REG_SCROLL: begin
                    if (wstrb[0]) scroll_x <= wdata[7:0];
                    if (wstrb[1]) scroll_y <= wdata[15:8];
                end
                REG_ADDR: begin
                    if (wstrb[0]) addr_q[7:0]  <= wdata[7:0];
                    if (wstrb[1]) addr_q[13:8] <= wdata[13:8];
                end
                REG_DATA: begin
                    if (wstrb[0]) addr_q <= addr_q + 14'd1; // advances even when dropped
                end
                default: ;
            endcase
        end
    end

    // memory strobes last one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vram_we <= 1'b0;
            chr_we  <= 1'b0;
        end else begin
            chr_we  <= data_wr && !render_en && (addr_q < CHR_TOP);
            vram_we <= data_wr && !render_en && (addr_q >= NT_BASE);
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            mem_addr  <= addr_q[12:0];
            mem_wdata <= wdata[7:0];
        end
    end

endmodule

//--- src/ppu_pkg.sv
package ppu_pkg;

    // nametable mirroring, CTRL bit 4
    typedef enum logic {
        HOR_MIRROR = 1'b0,
        VER_MIRROR = 1'b1
    } mirror_t;

    // base nametable, CTRL bits 3:2
    typedef enum logic [1:0] {
        TOP_L_TBL = 2'd0,
        TOP_R_TBL = 2'd1,
        BOT_L_TBL = 2'd2,
        BOT_R_TBL = 2'd3
    } name_tbl_t;

    // background pattern half, CTRL bit 1
    typedef enum logic {
        LEFT_TBL  = 1'b0,
        RIGHT_TBL = 1'b1
    } pattern_tbl_t;

    // register byte offsets on the AXI4-Lite slave
    localparam logic [4:0] REG_CTRL   = 5'h00;
    localparam logic [4:0] REG_SCROLL = 5'h04;
    localparam logic [4:0] REG_ADDR   = 5'h08;
    localparam logic [4:0] REG_DATA   = 5'h0C;

    localparam logic [10:0] ATTR_TBL_OFF = 11'h3C0; // attribute table inside a nametable

    localparam logic [13:0] CHR_TOP = 14'h2000; // pattern space ends here
    localparam logic [13:0] NT_BASE = 14'h2000; // nametable space starts here

    localparam int VISIBLE_ROWS = 240;
    localparam int VISIBLE_COLS = 256;

endpackage
